//--- ntm_dot_product.f
verilog/ntm_arith_pkg.sv
verilog/ntm_ctrl_pkg.sv
verilog/ntm_element_fifo.sv
verilog/ntm_scalar_multiplier.sv
verilog/ntm_product_stage.sv
verilog/ntm_dot_product.sv
verilog/ntm_dot_product_top.sv
tests/ntm_dot_product_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the dot-product testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ntm_dot_product.f \
  --top-module ntm_dot_product_tb -o ntm_dot_product_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/ntm_dot_product_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

//--- tests/ntm_dot_product_tb.sv
// Testbench for the streaming dot-product unit
// Random runs against a sum-of-products model, overflow, zero length,
// back-pressure on stream A and elements sent before START

`default_nettype none

module ntm_dot_product_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_SIZE  = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int MAX_LEN    = 12;
  localparam int TIMEOUT    = 2000;

  // Run flavours
  localparam int MODE_RANDOM     = 0;
  localparam int MODE_MAX        = 1;
  localparam int MODE_A_FIRST    = 2;
  localparam int MODE_LATE_START = 3;

  logic                 CLK;
  logic                 RST;
  logic                 START;
  logic [DATA_SIZE-1:0] LENGTH_IN;
  logic [DATA_SIZE-1:0] DATA_A_IN;
  logic [DATA_SIZE-1:0] DATA_B_IN;
  logic                 DATA_A_IN_ENABLE;
  logic                 DATA_B_IN_ENABLE;
  logic                 DATA_A_FULL;
  logic                 DATA_B_FULL;
  logic                 READY;
  logic [DATA_SIZE-1:0] DATA_OUT;
  logic                 DATA_OUT_ENABLE;

  int seed;
  int value_errors;
  int other_errors;
  bit timed_out;

  // Monitor counters that only ever grow
  int enable_pulses;
  int a_full_cycles;
  int b_full_cycles;

  // Elements and gaps of the current run
  logic [DATA_SIZE-1:0] elem_a [MAX_LEN];
  logic [DATA_SIZE-1:0] elem_b [MAX_LEN];
  int                   gap_a  [MAX_LEN];
  int                   gap_b  [MAX_LEN];

  ntm_dot_product_top #(
    .DATA_SIZE (DATA_SIZE),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (START),
    .LENGTH_IN       (LENGTH_IN),
    .DATA_A_IN       (DATA_A_IN),
    .DATA_B_IN       (DATA_B_IN),
    .DATA_A_IN_ENABLE(DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE(DATA_B_IN_ENABLE),
    .DATA_A_FULL     (DATA_A_FULL),
    .DATA_B_FULL     (DATA_B_FULL),
    .READY           (READY),
    .DATA_OUT        (DATA_OUT),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE)
  );

  // 40 ns period
  always #20 CLK = ~CLK;

  // Outputs sampled mid-cycle away from the driving edge
  always @(negedge CLK) begin
    if (DATA_OUT_ENABLE) begin
      enable_pulses <= enable_pulses + 1;
    end
    if (DATA_A_FULL) begin
      a_full_cycles <= a_full_cycles + 1;
    end
    if (DATA_B_FULL) begin
      b_full_cycles <= b_full_cycles + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Reference result from full 32-bit products with the low 16 bits kept at the end
  function automatic logic [DATA_SIZE-1:0] expected_sum(input int len);
    int unsigned total;
    total = 0;
    for (int i = 0; i < len; i++) begin
      total = total + 32'(elem_a[i]) * 32'(elem_b[i]);
    end
    return total[DATA_SIZE-1:0];
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_SIZE-1:0] expected,
                                 input logic [DATA_SIZE-1:0] actual);
    value_errors++;
    $display("ERROR %s expected %h got %h", name, expected, actual);
  endtask

  task automatic note_timeout(input string what);
    other_errors++;
    timed_out = 1'b1;
    $display("Timeout: %s", what);
  endtask

  task automatic make_elements(input int len, input int mode, input int gap_max);
    for (int i = 0; i < len; i++) begin
      if (mode == MODE_MAX) begin
        elem_a[i] = '1;
        elem_b[i] = '1;
      end else begin
        elem_a[i] = 16'($random(seed));
        elem_b[i] = 16'($random(seed));
      end
      gap_a[i] = rand_below(gap_max + 1);
      gap_b[i] = rand_below(gap_max + 1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stream drivers
  ////////////////////////////////////////////////////////////

  task automatic send_stream_a(input int len);
    int waited;
    for (int i = 0; i < len; i++) begin
      // Idle cycles before this element
      repeat (gap_a[i]) begin
        @(posedge CLK);
        DATA_A_IN_ENABLE <= 1'b0;
      end
      @(posedge CLK);
      DATA_A_IN        <= elem_a[i];
      DATA_A_IN_ENABLE <= 1'b1;
      // Hold until the FIFO has room and the next edge takes the element
      waited = 0;
      @(negedge CLK);
      while (DATA_A_FULL) begin
        waited++;
        if (waited > TIMEOUT) begin
          note_timeout("stream A stuck behind DATA_A_FULL");
          return;
        end
        @(negedge CLK);
      end
    end
    @(posedge CLK);
    DATA_A_IN_ENABLE <= 1'b0;
  endtask

  task automatic send_stream_b(input int len);
    int waited;
    for (int i = 0; i < len; i++) begin
      repeat (gap_b[i]) begin
        @(posedge CLK);
        DATA_B_IN_ENABLE <= 1'b0;
      end
      @(posedge CLK);
      DATA_B_IN        <= elem_b[i];
      DATA_B_IN_ENABLE <= 1'b1;
      waited = 0;
      @(negedge CLK);
      while (DATA_B_FULL) begin
        waited++;
        if (waited > TIMEOUT) begin
          note_timeout("stream B stuck behind DATA_B_FULL");
          return;
        end
        @(negedge CLK);
      end
    end
    @(posedge CLK);
    DATA_B_IN_ENABLE <= 1'b0;
  endtask

  task automatic feed_streams(input int len, input int mode);
    if (mode == MODE_A_FIRST) begin
      // Whole A stream before any B element
      send_stream_a(len);
      send_stream_b(len);
    end else begin
      fork
        send_stream_a(len);
        send_stream_b(len);
      join
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Control side
  ////////////////////////////////////////////////////////////

  task automatic start_and_check(input int len, input logic [DATA_SIZE-1:0] expected);
    int waited;
    int lat;
    waited = 0;
    @(negedge CLK);
    while (!READY) begin
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("READY stayed low before START");
        return;
      end
      @(negedge CLK);
    end
    @(posedge CLK);
    START     <= 1'b1;
    LENGTH_IN <= 16'(len);
    @(posedge CLK);
    START <= 1'b0;
    // START is taken on this edge and READY drops after it
    lat = 1;
    @(negedge CLK);
    if (READY !== 1'b0) begin
      report_mismatch("READY", 16'h0, 16'(READY));
    end
    while (!DATA_OUT_ENABLE) begin
      if (lat > TIMEOUT) begin
        note_timeout("DATA_OUT_ENABLE never pulsed after START");
        return;
      end
      @(negedge CLK);
      lat++;
    end
    if (DATA_OUT !== expected) begin
      report_mismatch("DATA_OUT", expected, DATA_OUT);
    end
    if (READY !== 1'b1) begin
      report_mismatch("READY", 16'h1, 16'(READY));
    end
    if (len == 0 && lat != 2) begin
      other_errors++;
      $display("Zero-length run finished %0d cycles after START instead of 2", lat);
    end
  endtask

  task automatic run_vector(input int len, input int mode, input int gap_max);
    logic [DATA_SIZE-1:0] expected;
    int pulses_before;
    int full_before;
    int b_full_before;
    make_elements(len, mode, gap_max);
    expected      = expected_sum(len);
    pulses_before = enable_pulses;
    full_before   = a_full_cycles;
    b_full_before = b_full_cycles;
    fork
      feed_streams(len, mode);
      begin
        // Elements queue up well ahead of START
        if (mode == MODE_LATE_START) begin
          repeat (30) @(posedge CLK);
        end
        start_and_check(len, expected);
      end
    join
    // Room for a stray second pulse to show
    repeat (4) @(negedge CLK);
    if (enable_pulses != pulses_before + 1) begin
      other_errors++;
      $display("Run of length %0d gave %0d result pulses instead of one", len,
               enable_pulses - pulses_before);
    end
    if (mode == MODE_A_FIRST && a_full_cycles == full_before) begin
      other_errors++;
      $display("DATA_A_FULL never rose while stream A was sent alone");
    end
    // More elements queued ahead of START than the B FIFO and product path hold
    if (mode == MODE_LATE_START && b_full_cycles == b_full_before) begin
      other_errors++;
      $display("DATA_B_FULL never rose while elements queued ahead of START");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int len;
    int gap_max;
    seed             = 78;
    value_errors     = 0;
    other_errors     = 0;
    timed_out        = 1'b0;
    enable_pulses    = 0;
    a_full_cycles    = 0;
    b_full_cycles    = 0;
    CLK              = 1'b0;
    RST              = 1'b1;
    START            = 1'b0;
    LENGTH_IN        = '0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;

    repeat (16) @(posedge CLK);
    RST <= 1'b0;

    // Idle state out of reset
    @(negedge CLK);
    if (READY !== 1'b1) begin
      report_mismatch("READY", 16'h1, 16'(READY));
    end
    if (DATA_OUT_ENABLE !== 1'b0) begin
      report_mismatch("DATA_OUT_ENABLE", 16'h0, 16'(DATA_OUT_ENABLE));
    end

    for (int r = 0; r < 30 && !timed_out; r++) begin
      len     = 1 + rand_below(MAX_LEN);
      gap_max = rand_below(4);
      run_vector(len, MODE_RANDOM, gap_max);
    end

    // Overflowing products and sum
    if (!timed_out) begin
      run_vector(MAX_LEN, MODE_MAX, 0);
    end
    if (!timed_out) begin
      run_vector(0, MODE_RANDOM, 0);
    end
    // Back-pressure on A
    if (!timed_out) begin
      run_vector(FIFO_DEPTH, MODE_A_FIRST, 1);
    end
    if (!timed_out) begin
      run_vector(MAX_LEN, MODE_LATE_START, 0);
    end

    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule : ntm_dot_product_tb

`default_nettype wire

//--- verilog/ntm_arith_pkg.sv
// Arithmetic package
// Default data width and the shift-add multiplier state encoding

`default_nettype none

package ntm_arith_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Element, product and result width
  localparam int DEFAULT_DATA_SIZE = 16;

  ////////////////////////////////////////////////////////////
  // Multiplier states
  ////////////////////////////////////////////////////////////

  // IDLE waits for START, SHIFT walks the multiplier bits
  typedef enum logic {
    IDLE  = 1'b0,
    SHIFT = 1'b1
  } mult_state_t;

endpackage : ntm_arith_pkg

`default_nettype wire

//--- verilog/ntm_ctrl_pkg.sv
// Control package
// Default FIFO depth and the dot-product controller state encoding

`default_nettype none

package ntm_ctrl_pkg;

  // Entries per FIFO, power of two so pointers wrap naturally
  localparam int DEFAULT_FIFO_DEPTH = 4;

  ////////////////////////////////////////////////////////////
  // Controller states
  ////////////////////////////////////////////////////////////

  // STARTER idles with READY high
  // ACCUMULATE pops and sums products
  // DONE is the cycle with DATA_OUT_ENABLE high
  typedef enum logic [1:0] {
    STARTER    = 2'd0,
    ACCUMULATE = 2'd1,
    DONE       = 2'd2
  } dot_state_t;

endpackage : ntm_ctrl_pkg

`default_nettype wire

//--- verilog/ntm_dot_product.sv
// Dot-product controller
// Counts and accumulates products, reports the sum with a one-cycle enable

`default_nettype none

module ntm_dot_product #(
  parameter int DATA_SIZE = ntm_arith_pkg::DEFAULT_DATA_SIZE
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire  [DATA_SIZE-1:0] LENGTH_IN,
  output logic                 READY,
  input  wire  [DATA_SIZE-1:0] PRODUCT_HEAD,
  input  wire                  PRODUCT_EMPTY,
  output logic                 PRODUCT_POP,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 DATA_OUT_ENABLE
);

  import ntm_ctrl_pkg::*;

  dot_state_t state;

  // Run length and products consumed so far
  logic [DATA_SIZE-1:0] length_r;
  logic [DATA_SIZE-1:0] count;

  // Running sum, wraps modulo 2^DATA_SIZE
  logic [DATA_SIZE-1:0] acc;

  logic accept;
  logic finish;

  // START only counts while idle
  assign accept = READY && START;

  // All products in
  assign finish = (state == ACCUMULATE) && (count == length_r);

  // Pop while products are still owed
  assign PRODUCT_POP = (state == ACCUMULATE) && !PRODUCT_EMPTY && (count != length_r);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      count           <= '0;
      READY           <= 1'b1;
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= 1'b0;
      case (state)
        // DONE is idle too, READY is already high there
        STARTER, DONE: begin
          if (accept) begin
            state <= ACCUMULATE;
            count <= '0;
            READY <= 1'b0;
          end else begin
            state <= STARTER;
          end
        end
        ACCUMULATE: begin
          if (PRODUCT_POP) begin
            count <= count + 1'b1;
          end
          if (finish) begin
            state           <= DONE;
            READY           <= 1'b1;
            DATA_OUT_ENABLE <= 1'b1;
          end
        end
        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Accumulator and result
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (accept) begin
      // New run
      length_r <= LENGTH_IN;
      acc      <= '0;
    end else if (PRODUCT_POP) begin
      acc <= acc + PRODUCT_HEAD;
    end
    // Sum registered alongside the enable
    if (finish) begin
      DATA_OUT <= acc;
    end
  end

endmodule : ntm_dot_product

`default_nettype wire

//--- verilog/ntm_dot_product_top.sv
// Streaming dot-product unit
// Element FIFOs, product stage, product FIFO and controller

`default_nettype none

module ntm_dot_product_top #(
  parameter int DATA_SIZE  = ntm_arith_pkg::DEFAULT_DATA_SIZE,
  parameter int FIFO_DEPTH = ntm_ctrl_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire  [DATA_SIZE-1:0] LENGTH_IN,
  input  wire  [DATA_SIZE-1:0] DATA_A_IN,
  input  wire  [DATA_SIZE-1:0] DATA_B_IN,
  input  wire                  DATA_A_IN_ENABLE,
  input  wire                  DATA_B_IN_ENABLE,
  output logic                 DATA_A_FULL,
  output logic                 DATA_B_FULL,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 DATA_OUT_ENABLE
);

  // Element heads toward the product stage
  logic [DATA_SIZE-1:0] a_head;
  logic [DATA_SIZE-1:0] b_head;
  logic                 a_empty;
  logic                 b_empty;
  logic                 element_pop;

  // Product path
  logic [DATA_SIZE-1:0] product;
  logic                 product_push;
  logic                 product_full;
  logic [DATA_SIZE-1:0] product_head;
  logic                 product_empty;
  logic                 product_pop;

  ////////////////////////////////////////////////////////////
  // Element FIFOs
  ////////////////////////////////////////////////////////////

  ntm_element_fifo #(
    .DATA_SIZE (DATA_SIZE),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) a_fifo_i (
    .CLK      (CLK),
    .RST      (RST),
    .PUSH     (DATA_A_IN_ENABLE),
    .PUSH_DATA(DATA_A_IN),
    .POP      (element_pop),
    .HEAD_DATA(a_head),
    .FULL     (DATA_A_FULL),
    .EMPTY    (a_empty)
  );

  ntm_element_fifo #(
    .DATA_SIZE (DATA_SIZE),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) b_fifo_i (
    .CLK      (CLK),
    .RST      (RST),
    .PUSH     (DATA_B_IN_ENABLE),
    .PUSH_DATA(DATA_B_IN),
    .POP      (element_pop),
    .HEAD_DATA(b_head),
    .FULL     (DATA_B_FULL),
    .EMPTY    (b_empty)
  );

  // Multiply stage, pops both element FIFOs together
  ntm_product_stage #(
    .DATA_SIZE(DATA_SIZE)
  ) product_stage_i (
    .CLK         (CLK),
    .RST         (RST),
    .A_HEAD      (a_head),
    .B_HEAD      (b_head),
    .A_EMPTY     (a_empty),
    .B_EMPTY     (b_empty),
    .ELEMENT_POP (element_pop),
    .PRODUCT_FULL(product_full),
    .PRODUCT_PUSH(product_push),
    .PRODUCT     (product)
  );

  ntm_element_fifo #(
    .DATA_SIZE (DATA_SIZE),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) product_fifo_i (
    .CLK      (CLK),
    .RST      (RST),
    .PUSH     (product_push),
    .PUSH_DATA(product),
    .POP      (product_pop),
    .HEAD_DATA(product_head),
    .FULL     (product_full),
    .EMPTY    (product_empty)
  );

  ////////////////////////////////////////////////////////////
  // Controller
  ////////////////////////////////////////////////////////////

  ntm_dot_product #(
    .DATA_SIZE(DATA_SIZE)
  ) dot_product_i (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .LENGTH_IN      (LENGTH_IN),
    .READY          (READY),
    .PRODUCT_HEAD   (product_head),
    .PRODUCT_EMPTY  (product_empty),
    .PRODUCT_POP    (product_pop),
    .DATA_OUT       (DATA_OUT),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE)
  );

endmodule : ntm_dot_product_top

`default_nettype wire

//--- verilog/ntm_element_fifo.sv
// Synchronous FIFO with full and empty flags
// Serves the A and B element streams and the product stream

`default_nettype none

module ntm_element_fifo #(
  parameter int DATA_SIZE  = ntm_arith_pkg::DEFAULT_DATA_SIZE,
  parameter int FIFO_DEPTH = ntm_ctrl_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  PUSH,
  input  wire  [DATA_SIZE-1:0] PUSH_DATA,
  input  wire                  POP,
  output logic [DATA_SIZE-1:0] HEAD_DATA,
  output logic                 FULL,
  output logic                 EMPTY
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Storage
  logic [DATA_SIZE-1:0] mem [FIFO_DEPTH];

  // Pointers and occupancy
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Qualified requests
  logic push_ok;
  logic pop_ok;

  assign push_ok = PUSH && !FULL;
  assign pop_ok  = POP && !EMPTY;

  // Flags straight from the occupancy count
  assign FULL      = (count == CNT_W'(FIFO_DEPTH));
  assign EMPTY     = (count == '0);
  assign HEAD_DATA = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Pointer and count update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push_ok && !pop_ok) begin
        count <= count + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  // Write port
  always_ff @(posedge CLK) begin
    if (push_ok) begin
      mem[wr_ptr] <= PUSH_DATA;
    end
  end

endmodule : ntm_element_fifo

`default_nettype wire

//--- verilog/ntm_product_stage.sv
// Product stage
// Pairs the A and B FIFO heads, multiplies them, pushes the product

`default_nettype none

module ntm_product_stage #(
  parameter int DATA_SIZE = ntm_arith_pkg::DEFAULT_DATA_SIZE
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire  [DATA_SIZE-1:0] A_HEAD,
  input  wire  [DATA_SIZE-1:0] B_HEAD,
  input  wire                  A_EMPTY,
  input  wire                  B_EMPTY,
  output logic                 ELEMENT_POP,
  input  wire                  PRODUCT_FULL,
  output logic                 PRODUCT_PUSH,
  output logic [DATA_SIZE-1:0] PRODUCT
);

  // Busy from multiplier start until the product leaves
  logic pending;

  // Finished product waiting on a full product FIFO
  logic held;

  logic mult_start;
  logic mult_ready;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Both heads present and nothing in flight
  assign mult_start  = !A_EMPTY && !B_EMPTY && !pending;
  assign ELEMENT_POP = mult_start;

  // Push on READY directly, or later from the held state
  assign PRODUCT_PUSH = (mult_ready || held) && !PRODUCT_FULL;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pending <= 1'b0;
      held    <= 1'b0;
    end else begin
      if (mult_start) begin
        pending <= 1'b1;
      end else if (PRODUCT_PUSH) begin
        pending <= 1'b0;
      end
      // Stall while the product FIFO is full
      if (PRODUCT_PUSH) begin
        held <= 1'b0;
      end else if (mult_ready) begin
        held <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////////////////////////

  // DATA_OUT stays stable until the next start, so it feeds PRODUCT
  ntm_scalar_multiplier #(
    .DATA_SIZE(DATA_SIZE)
  ) multiplier_i (
    .CLK      (CLK),
    .RST      (RST),
    .START    (mult_start),
    .DATA_A_IN(A_HEAD),
    .DATA_B_IN(B_HEAD),
    .READY    (mult_ready),
    .DATA_OUT (PRODUCT)
  );

endmodule : ntm_product_stage

`default_nettype wire

//--- verilog/ntm_scalar_multiplier.sv
// Sequential shift-add scalar multiplier
// One bit of the multiplier per cycle, result truncated to DATA_SIZE

`default_nettype none

module ntm_scalar_multiplier #(
  parameter int DATA_SIZE = ntm_arith_pkg::DEFAULT_DATA_SIZE
) (
  input  wire                  CLK,
  input  wire                  RST,
  input  wire                  START,
  input  wire  [DATA_SIZE-1:0] DATA_A_IN,
  input  wire  [DATA_SIZE-1:0] DATA_B_IN,
  output logic                 READY,
  output logic [DATA_SIZE-1:0] DATA_OUT
);

  import ntm_arith_pkg::*;

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  mult_state_t state;

  // Bit index into the multiplier
  logic [CNT_W-1:0] bit_cnt;
  logic             last_bit;

  // Operand shifters and running sum
  logic [DATA_SIZE-1:0] multiplicand;
  logic [DATA_SIZE-1:0] multiplier;
  logic [DATA_SIZE-1:0] partial;
  logic [DATA_SIZE-1:0] partial_next;

  // Add shifted A when the current B bit is set
  assign partial_next = multiplier[0] ? partial + multiplicand : partial;
  assign last_bit     = (bit_cnt == CNT_W'(DATA_SIZE - 1));

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= IDLE;
      bit_cnt <= '0;
      READY   <= 1'b0;
    end else begin
      // READY is a single-cycle pulse
      READY <= 1'b0;
      case (state)
        IDLE: begin
          if (START) begin
            state   <= SHIFT;
            bit_cnt <= '0;
          end
        end
        SHIFT: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) begin
            state <= IDLE;
            READY <= 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (state == IDLE && START) begin
      // Latch operands, clear the sum
      multiplicand <= DATA_A_IN;
      multiplier   <= DATA_B_IN;
      partial      <= '0;
    end else if (state == SHIFT) begin
      partial      <= partial_next;
      multiplicand <= multiplicand << 1;
      multiplier   <= multiplier >> 1;
      // Result holds until the next run finishes
      if (last_bit) begin
        DATA_OUT <= partial_next;
      end
    end
  end

endmodule : ntm_scalar_multiplier

`default_nettype wire
